// ==== dirty_tracker.f ====
+incdir+verilog
verilog/dirty_pkg.sv
verilog/dirty_port_if.sv
verilog/dirty_way_array.sv
verilog/flush_controller.sv
verilog/dirty_tracker_top.sv
verification/tb_dirty_tracker.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the dirty tracker testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
FAIL_MSG="=== FAIL ==="

verilator --binary --timing \
    --top-module tb_dirty_tracker \
    --Mdir "$BUILD_DIR" \
    -f dirty_tracker.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vtb_dirty_tracker" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "$FAIL_MSG" "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi

echo "simulation finished without failures"
exit 0

// ==== verification/tb_dirty_tracker.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "dirty_tracker_defines.svh"

module tb_dirty_tracker;

    localparam int RAND_UPDATES    = 48;
    localparam int NUM_OPS         = 2 * RAND_UPDATES + 3 * 2 * `DT_SETS + 16;
    localparam int WATCHDOG_CYCLES = NUM_OPS * 150 + 1000;
    localparam int FLUSH_LIMIT     = 40 * `DT_SETS;   // room for random ready stalls

    logic                 clk;
    logic                 rstn;
    dirty_pkg::way_mask_t wr_way_en;
    dirty_pkg::set_addr_t wr_set;
    logic                 wr_dirty;
    dirty_pkg::set_addr_t rd_set;
    logic                 rd_way;
    logic                 rd_dirty;
    logic                 flush_req;
    logic                 flush_ready;
    logic                 flush_valid;
    dirty_pkg::set_addr_t flush_set;
    dirty_pkg::way_mask_t flush_ways;
    logic                 flush_done;
    logic                 busy;

    dirty_pkg::way_mask_t model [`DT_SETS];   // reference dirty bits, per set
    logic [31:0]          lfsr_state;

    // bookkeeping shared with the offer checker
    int                      exp_from;
    dirty_pkg::total_count_t offer_count;
    dirty_pkg::total_count_t line_total;
    dirty_pkg::total_count_t valid_cycles;
    dirty_pkg::total_count_t done_count;
    logic                    held_valid;
    dirty_pkg::set_addr_t    held_set;
    dirty_pkg::way_mask_t    held_ways;
    logic                    done_due;     // last dirty line just accepted

    dirty_tracker_top DUT (
        .clk         (clk),
        .rstn        (rstn),
        .wr_way_en   (wr_way_en),
        .wr_set      (wr_set),
        .wr_dirty    (wr_dirty),
        .rd_set      (rd_set),
        .rd_way      (rd_way),
        .rd_dirty    (rd_dirty),
        .flush_req   (flush_req),
        .flush_ready (flush_ready),
        .flush_valid (flush_valid),
        .flush_set   (flush_set),
        .flush_ways  (flush_ways),
        .flush_done  (flush_done),
        .busy        (busy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits       = {bits[30:0], lfsr_state[31]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic logic expected_rd(input dirty_pkg::set_addr_t set, input logic way);
        return model[set][way];
    endfunction

    // first dirty set at or after from, with its ways
    function automatic logic next_dirty(input int from, output dirty_pkg::set_addr_t set,
                                        output dirty_pkg::way_mask_t ways);
        set  = '0;
        ways = '0;
        for (int s = from; s < `DT_SETS; s++) begin
            if (model[s] != '0) begin
                set  = dirty_pkg::set_addr_t'(s);
                ways = model[s];
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail %s: expected %0b, actual %0b", name, exp, act);
            abort_run();
        end
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail %s: expected %0b, actual %0b", name, exp, act);
            abort_run();
        end
    endtask

    task automatic compare_offer(input string name,
                                 input dirty_pkg::set_addr_t exp_set,
                                 input dirty_pkg::way_mask_t exp_ways,
                                 input dirty_pkg::set_addr_t act_set,
                                 input dirty_pkg::way_mask_t act_ways);
        if (act_set !== exp_set || act_ways !== exp_ways) begin
            $display("Fail %s: expected set %0d ways %b, actual set %0d ways %b",
                     name, exp_set, exp_ways, act_set, act_ways);
            abort_run();
        end
    endtask

    task automatic compare_count(input string name, input dirty_pkg::total_count_t exp,
                                 input dirty_pkg::total_count_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    // offer checker sampling each cycle ahead of the transfer edge
    always @(negedge clk) begin
        dirty_pkg::set_addr_t exp_set;
        dirty_pkg::way_mask_t exp_ways;
        if (rstn) begin
            if (done_due) begin
                compare_flag("flush_done after last offer", 1'b1, flush_done);
                done_due = 1'b0;
            end
            if (flush_done) begin
                done_count = done_count + 1'b1;
            end
            if (held_valid && !flush_valid) begin
                $display("offer for set %0d was withdrawn before it was accepted", held_set);
                abort_run();
            end
            if (flush_valid) begin
                valid_cycles = valid_cycles + 1'b1;
                if (held_valid) begin
                    compare_offer("offer held under stall", held_set, held_ways,
                                  flush_set, flush_ways);
                end
                if (flush_ready) begin
                    if (!next_dirty(exp_from, exp_set, exp_ways)) begin
                        $display("set %0d offered but no dirty set was left", flush_set);
                        abort_run();
                    end
                    compare_offer("accepted offer", exp_set, exp_ways, flush_set, flush_ways);
                    exp_from    = int'(flush_set) + 1;   // ascending, each once
                    offer_count = offer_count + 1'b1;
                    line_total  = line_total + dirty_pkg::total_count_t'(flush_ways[0])
                                             + dirty_pkg::total_count_t'(flush_ways[1]);
                    held_valid  = 1'b0;
                    done_due    = !next_dirty(exp_from, exp_set, exp_ways);   // remaining hits zero
                end else begin
                    held_valid = 1'b1;
                    held_set   = flush_set;
                    held_ways  = flush_ways;
                end
            end
        end
    end

    task automatic apply_update(input dirty_pkg::way_mask_t ways,
                                input dirty_pkg::set_addr_t set, input logic value);
        @(posedge clk);
        wr_way_en <= ways;
        wr_set    <= set;
        wr_dirty  <= value;
        @(posedge clk);   // write lands here
        wr_way_en <= '0;
        for (int w = 0; w < `DT_WAYS; w++) begin
            if (ways[w]) begin
                model[set][w] = value;
            end
        end
    endtask

    task automatic check_read(input string name, input dirty_pkg::set_addr_t set,
                              input logic way);
        @(posedge clk);
        rd_set <= set;
        rd_way <= way;
        @(negedge clk);
        compare_bit(name, expected_rd(set, way), rd_dirty);
    endtask

    task automatic check_all_reads(input string name);
        for (int s = 0; s < `DT_SETS; s++) begin
            check_read({name, " way 0"}, dirty_pkg::set_addr_t'(s), 1'b0);
            check_read({name, " way 1"}, dirty_pkg::set_addr_t'(s), 1'b1);
        end
    endtask

    task automatic update_and_check(input dirty_pkg::way_mask_t ways,
                                    input dirty_pkg::set_addr_t set, input logic value);
        apply_update(ways, set, value);
        check_read("update readback way 0", set, 1'b0);
        check_read("update readback way 1", set, 1'b1);
    endtask

    task automatic random_updates(input int count);
        logic [31:0]          r;
        dirty_pkg::way_mask_t ways;
        dirty_pkg::set_addr_t set;
        logic                 value;
        for (int i = 0; i < count; i++) begin
            take_bits(2, r);
            ways = dirty_pkg::way_mask_t'(r[1:0]);
            if (ways == '0) begin
                ways = 2'b01;
            end
            take_bits(`DT_SET_BITS, r);
            set = r[`DT_SET_BITS-1:0];
            take_bits(2, r);
            value = |r[1:0];   // mostly dirty, some cleans
            update_and_check(ways, set, value);
        end
    endtask

    task automatic run_flush(input string name, input logic stall);
        logic [31:0]             r;
        int                      cycles;
        dirty_pkg::total_count_t exp_sets;
        dirty_pkg::total_count_t exp_lines;
        dirty_pkg::set_addr_t    left_set;
        dirty_pkg::way_mask_t    left_ways;
        exp_sets  = '0;
        exp_lines = '0;
        for (int s = 0; s < `DT_SETS; s++) begin
            if (model[s] != '0) begin
                exp_sets = exp_sets + 1'b1;
            end
            exp_lines = exp_lines + dirty_pkg::total_count_t'(model[s][0])
                                  + dirty_pkg::total_count_t'(model[s][1]);
        end
        exp_from     = 0;
        offer_count  = '0;
        line_total   = '0;
        valid_cycles = '0;
        done_count   = '0;
        held_valid   = 1'b0;
        @(posedge clk);
        flush_req   <= 1'b1;
        flush_ready <= 1'b1;
        @(posedge clk);
        flush_req <= 1'b0;
        @(negedge clk);
        compare_flag({name, " busy after request"}, 1'b1, busy);
        cycles = 0;
        while (done_count == '0) begin
            @(posedge clk);
            if (stall) begin
                take_bits(1, r);
                flush_ready <= r[0];
            end else begin
                flush_ready <= 1'b1;
            end
            cycles++;
            if (cycles > FLUSH_LIMIT) begin
                $display("%s did not reach flush_done in %0d cycles", name, FLUSH_LIMIT);
                abort_run();
            end
        end
        @(negedge clk);
        compare_flag({name, " busy after done"}, 1'b0, busy);
        compare_flag({name, " valid after done"}, 1'b0, flush_valid);
        compare_count({name, " offered sets"}, exp_sets, offer_count);
        compare_count({name, " offered lines"}, exp_lines, line_total);
        compare_count({name, " done pulses"}, 8'd1, done_count);
        if (exp_sets == '0) begin
            compare_count({name, " valid cycles"}, '0, valid_cycles);
        end
        if (next_dirty(exp_from, left_set, left_ways)) begin
            $display("%s ended while set %0d was still dirty", name, left_set);
            abort_run();
        end
        for (int s = 0; s < `DT_SETS; s++) begin
            model[s] = '0;   // flush wipes everything
        end
        flush_ready <= 1'b1;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout, the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        abort_run();
    end

    initial begin
        lfsr_state   = 32'hd430_da6a;
        done_count   = '0;
        offer_count  = '0;
        line_total   = '0;
        valid_cycles = '0;
        held_valid   = 1'b0;
        held_set     = '0;
        held_ways    = '0;
        done_due     = 1'b0;
        exp_from     = 0;
        for (int s = 0; s < `DT_SETS; s++) begin
            model[s] = '0;
        end
        rstn        <= 1'b0;
        wr_way_en   <= '0;
        wr_set      <= '0;
        wr_dirty    <= 1'b0;
        rd_set      <= '0;
        rd_way      <= 1'b0;
        flush_req   <= 1'b0;
        flush_ready <= 1'b1;
        repeat (3) @(posedge clk);
        rstn <= 1'b1;

        // state after reset
        @(negedge clk);
        compare_flag("busy after reset", 1'b0, busy);
        compare_flag("valid after reset", 1'b0, flush_valid);
        check_all_reads("reads after reset");
        run_flush("empty flush", 1'b0);

        // random updates, then a flush at full speed
        random_updates(RAND_UPDATES);
        run_flush("flush after updates", 1'b0);
        check_all_reads("reads after flush");

        // dirty then cleaned lines, repeated writes, last set
        random_updates(RAND_UPDATES);
        update_and_check(2'b11, 6'd10, 1'b1);
        update_and_check(2'b01, 6'd10, 1'b0);   // only way 1 left
        update_and_check(2'b01, 6'd20, 1'b1);
        update_and_check(2'b01, 6'd20, 1'b1);
        update_and_check(2'b11, 6'd20, 1'b0);   // fully clean again
        update_and_check(2'b10, 6'd63, 1'b1);
        update_and_check(2'b01, 6'd0, 1'b1);
        run_flush("stalled flush", 1'b1);
        run_flush("second flush", 1'b0);
        check_all_reads("reads after second flush");

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/dirty_pkg.sv ====
`default_nettype none

`include "dirty_tracker_defines.svh"

package dirty_pkg;

    typedef logic [`DT_SET_BITS-1:0] set_addr_t;

    // bit 0 is way 0
    typedef logic [`DT_WAYS-1:0] way_mask_t;

    // per way, up to 64 lines
    typedef logic [`DT_SET_BITS:0] dirty_count_t;

    // both ways together, up to 128 lines
    typedef logic [`DT_SET_BITS+1:0] total_count_t;

    typedef enum logic [1:0] {
        st_idle,
        st_search,
        st_offer,
        st_done
    } flush_state_t;

endpackage

`default_nettype wire

// ==== verilog/dirty_port_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// link between the flush controller side and one way's dirty array
interface dirty_port_if;

    logic                    wr_en;
    dirty_pkg::set_addr_t    wr_set;
    logic                    wr_dirty;     // value written into the bit
    dirty_pkg::set_addr_t    rd_set;
    logic                    rd_bit;
    dirty_pkg::set_addr_t    scan_set;     // flush walk position
    logic                    scan_bit;
    logic                    clear_all;    // wipe at end of flush
    dirty_pkg::dirty_count_t line_count;

    modport array (
        input  wr_en, wr_set, wr_dirty,
        input  rd_set, scan_set, clear_all,
        output rd_bit, scan_bit, line_count
    );

    modport ctrl (
        output wr_en, wr_set, wr_dirty,
        output rd_set, scan_set, clear_all,
        input  rd_bit, scan_bit, line_count
    );

endinterface

`default_nettype wire

// ==== verilog/dirty_tracker_defines.svh ====
`ifndef DIRTY_TRACKER_DEFINES_SVH
`define DIRTY_TRACKER_DEFINES_SVH

// cache geometry seen by the dirty bookkeeping

`define DT_SET_BITS 6   // set index width

`define DT_SETS (1 << `DT_SET_BITS)   // 64 sets

`define DT_WAYS 2   // two-way set associative

`endif

// ==== verilog/dirty_tracker_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module dirty_tracker_top (
    input  logic                  clk,
    input  logic                  rstn,
    input  dirty_pkg::way_mask_t  wr_way_en,
    input  dirty_pkg::set_addr_t  wr_set,
    input  logic                  wr_dirty,
    input  dirty_pkg::set_addr_t  rd_set,
    input  logic                  rd_way,
    output logic                  rd_dirty,
    input  logic                  flush_req,
    input  logic                  flush_ready,
    output logic                  flush_valid,
    output dirty_pkg::set_addr_t  flush_set,
    output dirty_pkg::way_mask_t  flush_ways,
    output logic                  flush_done,
    output logic                  busy
);

    dirty_port_if u_port0 ();
    dirty_port_if u_port1 ();

    // way 0 update and read fields
    assign u_port0.wr_en    = wr_way_en[0];
    assign u_port0.wr_set   = wr_set;
    assign u_port0.wr_dirty = wr_dirty;
    assign u_port0.rd_set   = rd_set;

    // way 1 gets the same fields
    assign u_port1.wr_en    = wr_way_en[1];
    assign u_port1.wr_set   = wr_set;
    assign u_port1.wr_dirty = wr_dirty;
    assign u_port1.rd_set   = rd_set;

    dirty_way_array u_way0 (
        .clk  (clk),
        .rstn (rstn),
        .port (u_port0.array)
    );

    dirty_way_array u_way1 (
        .clk  (clk),
        .rstn (rstn),
        .port (u_port1.array)
    );

    flush_controller u_ctrl (
        .clk         (clk),
        .rstn        (rstn),
        .way0        (u_port0.ctrl),
        .way1        (u_port1.ctrl),
        .rd_way      (rd_way),
        .rd_dirty    (rd_dirty),
        .flush_req   (flush_req),
        .flush_ready (flush_ready),
        .flush_valid (flush_valid),
        .flush_set   (flush_set),
        .flush_ways  (flush_ways),
        .flush_done  (flush_done),
        .busy        (busy)
    );

endmodule

`default_nettype wire

// ==== verilog/dirty_way_array.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "dirty_tracker_defines.svh"

module dirty_way_array (
    input logic         clk,
    input logic         rstn,
    dirty_port_if.array port
);

    logic [`DT_SETS-1:0]     dirty_bits;   // one bit per set
    dirty_pkg::dirty_count_t count;

    logic old_bit;      // stored bit at the write set
    logic bit_flip;     // write really changes the stored bit
    logic bit_rise;
    logic bit_fall;

    assign old_bit  = dirty_bits[port.wr_set];
    assign bit_flip = port.wr_en && (old_bit != port.wr_dirty);
    assign bit_rise = bit_flip && port.wr_dirty;
    assign bit_fall = bit_flip && !port.wr_dirty;

    // bit storage
    always_ff @(posedge clk) begin
        if (!rstn) begin
            dirty_bits <= '0;
        end else if (port.clear_all) begin
            dirty_bits <= '0;                       // flush finished
        end else if (bit_flip) begin
            dirty_bits[port.wr_set] <= port.wr_dirty;
        end
    end

    // running number of dirty lines in this way
    always_ff @(posedge clk) begin
        if (!rstn) begin
            count <= '0;
        end else if (port.clear_all) begin
            count <= '0;
        end else if (bit_rise) begin
            count <= count + 1'b1;                  // 0 -> 1
        end else if (bit_fall) begin
            count <= count - 1'b1;                  // 1 -> 0
        end
    end

    // combinational reads
    assign port.rd_bit     = dirty_bits[port.rd_set];
    assign port.scan_bit   = dirty_bits[port.scan_set];   // walk probe
    assign port.line_count = count;

endmodule

`default_nettype wire

// ==== verilog/flush_controller.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "dirty_tracker_defines.svh"

module flush_controller (
    input  logic                  clk,
    input  logic                  rstn,
    dirty_port_if.ctrl            way0,
    dirty_port_if.ctrl            way1,
    input  logic                  rd_way,
    output logic                  rd_dirty,
    input  logic                  flush_req,
    input  logic                  flush_ready,
    output logic                  flush_valid,
    output dirty_pkg::set_addr_t  flush_set,
    output dirty_pkg::way_mask_t  flush_ways,
    output logic                  flush_done,
    output logic                  busy
);

    localparam dirty_pkg::set_addr_t LAST_SET = dirty_pkg::set_addr_t'(`DT_SETS - 1);

    dirty_pkg::flush_state_t state;
    dirty_pkg::flush_state_t next_state;

    dirty_pkg::set_addr_t    scan_pos;     // current walk set
    dirty_pkg::total_count_t remaining;    // dirty lines not yet offered
    dirty_pkg::total_count_t total_lines;
    dirty_pkg::total_count_t mask_ones;
    dirty_pkg::total_count_t remaining_after;
    dirty_pkg::way_mask_t    scan_mask;

    logic set_hit;       // any way dirty at scan_pos
    logic at_last;
    logic transfer;

    // host read path
    assign rd_dirty = rd_way ? way1.rd_bit : way0.rd_bit;

    assign scan_mask   = {way1.scan_bit, way0.scan_bit};
    assign set_hit     = |scan_mask;
    assign at_last     = (scan_pos == LAST_SET);
    assign total_lines = dirty_pkg::total_count_t'(way0.line_count)
                       + dirty_pkg::total_count_t'(way1.line_count);

    // number of ways in the offered mask
    always_comb begin
        mask_ones = '0;
        for (int w = 0; w < `DT_WAYS; w++) begin
            mask_ones = mask_ones + dirty_pkg::total_count_t'(scan_mask[w]);
        end
    end

    assign transfer        = (state == dirty_pkg::st_offer) && flush_ready;
    assign remaining_after = remaining - mask_ones;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= dirty_pkg::st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            dirty_pkg::st_idle: begin
                if (flush_req) begin
                    next_state = dirty_pkg::st_search;
                end
            end
            dirty_pkg::st_search: begin
                if (set_hit) begin
                    next_state = dirty_pkg::st_offer;       // same set
                end else if (remaining == '0 || at_last) begin
                    next_state = dirty_pkg::st_done;
                end
            end
            dirty_pkg::st_offer: begin
                if (flush_ready) begin
                    if (remaining_after == '0 || at_last) begin
                        next_state = dirty_pkg::st_done;
                    end else begin
                        next_state = dirty_pkg::st_search;
                    end
                end
            end
            dirty_pkg::st_done: begin
                next_state = dirty_pkg::st_idle;
            end
            default: begin
                next_state = dirty_pkg::st_idle;
            end
        endcase
    end

    // walk position and outstanding line total
    always_ff @(posedge clk) begin
        if (!rstn) begin
            scan_pos  <= '0;
            remaining <= '0;
        end else begin
            case (state)
                dirty_pkg::st_idle: begin
                    scan_pos <= '0;
                    if (flush_req) begin
                        remaining <= total_lines;   // snapshot at start
                    end
                end
                dirty_pkg::st_search: begin
                    if (!set_hit && remaining != '0 && !at_last) begin
                        scan_pos <= scan_pos + 1'b1;
                    end
                end
                dirty_pkg::st_offer: begin
                    if (transfer) begin
                        remaining <= remaining_after;
                        if (remaining_after != '0 && !at_last) begin
                            scan_pos <= scan_pos + 1'b1;   // skip accepted set
                        end
                    end
                end
                default: begin
                    scan_pos  <= '0;
                    remaining <= '0;
                end
            endcase
        end
    end

    // both arrays follow the walk
    assign way0.scan_set  = scan_pos;
    assign way1.scan_set  = scan_pos;
    assign way0.clear_all = (state == dirty_pkg::st_done);
    assign way1.clear_all = (state == dirty_pkg::st_done);

    // write-back offer
    assign flush_valid = (state == dirty_pkg::st_offer);
    assign flush_set   = scan_pos;
    assign flush_ways  = scan_mask;
    assign flush_done  = (state == dirty_pkg::st_done);
    assign busy        = (state != dirty_pkg::st_idle);

endmodule

`default_nettype wire
